//--- common/motor_pkg.sv
package motor_pkg;

  typedef logic [6:0]         reg_addr_t;
  typedef logic [31:0]        reg_data_t;
  typedef logic [15:0]        step_count_t;
  typedef logic [15:0]        step_period_t;   // CLK cycles between steps
  typedef logic [7:0]         current_t;       // 255 is full scale
  typedef logic [2:0]         microstep_t;     // 0 full step .. 4 is 1/16
  typedef logic [5:0]         phase_idx_t;     // 64 per electrical cycle
  typedef logic signed [31:0] enc_count_t;

  localparam reg_data_t id_value = 32'h5241_5001;

  // Register word addresses
  localparam reg_addr_t addr_id        = 7'h00;
  localparam reg_addr_t addr_config    = 7'h01;
  localparam reg_addr_t addr_period    = 7'h02;
  localparam reg_addr_t addr_status    = 7'h03;
  localparam reg_addr_t addr_encoder   = 7'h04;
  localparam reg_addr_t addr_move_base = 7'h10;  // One word per motor

  typedef struct packed {
    logic      cyc;
    logic      stb;
    logic      we;
    reg_addr_t adr;
    reg_data_t dat;
  } wb_req_t;

  typedef struct packed {
    logic      ack;
    reg_data_t dat;
  } wb_rsp_t;

  typedef struct packed {
    microstep_t microsteps;
    current_t   current;
  } drive_cfg_t;

  typedef enum logic [1:0] {spi_idle, spi_addr, spi_data} spi_state_t;

  typedef enum logic {wb_idle, wb_busy} wb_state_t;

endpackage

//--- spi/spi_target.sv
module spi_target (
  input  logic               CLK,
  input  logic               resetn,
  input  logic               sck,
  input  logic               cs_n,
  input  logic               copi,
  output logic               cipo,
  output motor_pkg::wb_req_t wb_req,
  input  motor_pkg::wb_rsp_t wb_rsp
);

  logic [2:0]            sck_sync;  // Two sync stages plus last value
  logic [1:0]            cs_sync;
  logic [1:0]            copi_sync;
  logic                  sck_rise;
  logic                  sck_fall;
  logic                  cs_active;
  logic [5:0]            bit_cnt;
  logic [39:0]           shift_in;
  logic [39:0]           frame_next;
  logic                  start_rd;
  logic                  start_wr;
  logic                  req_we;
  motor_pkg::reg_addr_t  req_adr;
  motor_pkg::reg_data_t  req_dat;
  motor_pkg::reg_data_t  shift_out;
  motor_pkg::spi_state_t spi_state;
  motor_pkg::wb_state_t  wb_state;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_sync  <= '0;
      cs_sync   <= '1;
      copi_sync <= '0;
    end else begin
      sck_sync  <= {sck_sync[1:0], sck};
      cs_sync   <= {cs_sync[0], cs_n};
      copi_sync <= {copi_sync[0], copi};
    end
  end

  assign sck_rise   = sck_sync[1] & ~sck_sync[2];
  assign sck_fall   = ~sck_sync[1] & sck_sync[2];
  assign cs_active  = ~cs_sync[1];
  assign frame_next = {shift_in[38:0], copi_sync[1]};

  // Read goes out after the address byte, write after the last data bit
  assign start_rd = sck_rise && spi_state == motor_pkg::spi_addr && bit_cnt == 6'd7 &&
                    !frame_next[7];
  assign start_wr = sck_rise && spi_state == motor_pkg::spi_data && bit_cnt == 6'd39 &&
                    frame_next[39];

  always_ff @(posedge CLK) begin
    if (!resetn || !cs_active) begin
      spi_state <= motor_pkg::spi_idle;  // Partial frame dropped
      bit_cnt   <= '0;
    end else begin
      case (spi_state)
        motor_pkg::spi_idle: spi_state <= motor_pkg::spi_addr;
        motor_pkg::spi_addr: begin
          if (sck_rise) begin
            bit_cnt <= bit_cnt + 6'd1;
            if (bit_cnt == 6'd7) spi_state <= motor_pkg::spi_data;
          end
        end
        motor_pkg::spi_data: begin
          if (sck_rise) begin
            if (bit_cnt == 6'd39) begin
              bit_cnt   <= '0;
              spi_state <= motor_pkg::spi_addr;  // Next frame may follow
            end else begin
              bit_cnt <= bit_cnt + 6'd1;
            end
          end
        end
        default: spi_state <= motor_pkg::spi_idle;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (sck_rise) shift_in <= frame_next;
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      wb_state <= motor_pkg::wb_idle;
    end else if (wb_state == motor_pkg::wb_idle) begin
      if (start_rd || start_wr) wb_state <= motor_pkg::wb_busy;
    end else if (wb_rsp.ack) begin
      wb_state <= motor_pkg::wb_idle;
    end
  end

  always_ff @(posedge CLK) begin
    if (wb_state == motor_pkg::wb_idle && (start_rd || start_wr)) begin
      req_we  <= start_wr;
      req_adr <= start_wr ? frame_next[38:32] : frame_next[6:0];
      req_dat <= frame_next[31:0];
    end
  end

  assign wb_req = '{cyc: wb_state == motor_pkg::wb_busy,
                    stb: wb_state == motor_pkg::wb_busy,
                    we:  req_we,
                    adr: req_adr,
                    dat: req_dat};

  // CIPO shifter, loaded on read ack and shifted on falling SCK
  always_ff @(posedge CLK) begin
    if (!resetn || !cs_active) begin
      cipo      <= 1'b0;
      shift_out <= '0;
    end else if (wb_state == motor_pkg::wb_busy && wb_rsp.ack && !req_we) begin
      shift_out <= wb_rsp.dat;
    end else if (sck_fall) begin
      cipo      <= (spi_state == motor_pkg::spi_data) ? shift_out[31] : 1'b0;
      shift_out <= {shift_out[30:0], 1'b0};
    end
  end

endmodule

//--- src/motor_regs.sv
module motor_regs #(
  parameter int motor_count = 2
) (
  input  logic                                 CLK,
  input  logic                                 resetn,
  input  motor_pkg::wb_req_t                   wb_req,
  output motor_pkg::wb_rsp_t                   wb_rsp,
  input  motor_pkg::enc_count_t                enc_count,
  input  logic [motor_count-1:0]               busy,
  input  motor_pkg::step_count_t [motor_count-1:0] remaining,
  output logic [motor_count-1:0]               enable,
  output motor_pkg::drive_cfg_t                drive_cfg,
  output motor_pkg::step_period_t              step_period,
  output logic [motor_count-1:0]               move_load,
  output logic                                 move_dir,
  output motor_pkg::step_count_t               move_steps
);

  logic [7:0]           enable_mask;
  logic                 ack;
  logic                 wb_hit;   // First cycle of a transfer
  logic                 wr_en;
  logic                 move_hit;
  motor_pkg::reg_addr_t move_off;
  motor_pkg::reg_data_t rd_data;
  motor_pkg::reg_data_t rsp_dat;

  assign wb_hit   = wb_req.cyc && wb_req.stb && !ack;
  assign wr_en    = wb_hit && wb_req.we;
  assign move_off = wb_req.adr - motor_pkg::addr_move_base;  // Wraps high below base
  assign move_hit = int'(move_off) < motor_count;
  assign enable   = enable_mask[motor_count-1:0];
  assign wb_rsp   = '{ack: ack, dat: rsp_dat};

  always_comb begin
    rd_data = '0;
    case (wb_req.adr)
      motor_pkg::addr_id:      rd_data = motor_pkg::id_value;
      motor_pkg::addr_config:  rd_data = {8'd0, drive_cfg.current, 5'd0,
                                          drive_cfg.microsteps, enable_mask};
      motor_pkg::addr_period:  rd_data = {16'd0, step_period};
      motor_pkg::addr_status:  rd_data[motor_count-1:0] = ~busy;  // move_done
      motor_pkg::addr_encoder: rd_data = enc_count;
      default: begin
        for (int m = 0; m < motor_count; m++) begin
          if (move_off == motor_pkg::reg_addr_t'(m)) rd_data = {16'd0, remaining[m]};
        end
      end
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      ack         <= 1'b0;
      enable_mask <= '0;
      drive_cfg   <= '0;
      step_period <= '0;
      move_load   <= '0;
    end else begin
      ack <= wb_hit;
      for (int m = 0; m < motor_count; m++) begin
        move_load[m] <= wr_en && move_off == motor_pkg::reg_addr_t'(m);
      end
      if (wr_en) begin
        case (wb_req.adr)
          motor_pkg::addr_config: begin
            enable_mask          <= wb_req.dat[7:0];
            drive_cfg.microsteps <= wb_req.dat[10:8];
            drive_cfg.current    <= wb_req.dat[23:16];
          end
          motor_pkg::addr_period: step_period <= wb_req.dat[15:0];
          default: ;  // Read-only or move words
        endcase
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (wb_hit) rsp_dat <= rd_data;
    if (wr_en && move_hit) begin
      move_dir   <= wb_req.dat[31];
      move_steps <= wb_req.dat[15:0];
    end
  end

endmodule

//--- src/quad_enc.sv
module quad_enc (
  input  logic                  CLK,
  input  logic                  resetn,
  input  logic                  a,
  input  logic                  b,
  output motor_pkg::enc_count_t count
);

  logic [1:0] a_sync;
  logic [1:0] b_sync;
  logic       a_prev;
  logic       b_prev;
  logic       a_chg;
  logic       b_chg;
  logic       valid;
  logic       up;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      a_sync <= '0;
      b_sync <= '0;
      a_prev <= 1'b0;
      b_prev <= 1'b0;
    end else begin
      a_sync <= {a_sync[0], a};
      b_sync <= {b_sync[0], b};
      a_prev <= a_sync[1];
      b_prev <= b_sync[1];
    end
  end

  assign a_chg = a_sync[1] ^ a_prev;
  assign b_chg = b_sync[1] ^ b_prev;
  assign valid = a_chg ^ b_chg;         // Both changing at once is skipped
  assign up    = a_sync[1] ^ b_prev;    // A leading B

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      count <= '0;
    end else if (valid) begin
      count <= up ? count + 32'sd1 : count - 32'sd1;
    end
  end

endmodule

//--- stepper/step_gen.sv
module step_gen (
  input  logic                    CLK,
  input  logic                    resetn,
  input  logic                    load,
  input  logic                    load_dir,
  input  motor_pkg::step_count_t  load_steps,
  input  motor_pkg::step_period_t period,
  output logic                    step,
  output logic                    dir,
  output logic                    busy,
  output motor_pkg::step_count_t  remaining
);

  motor_pkg::step_period_t period_eff;
  motor_pkg::step_period_t period_q;   // Held for the whole move
  motor_pkg::step_period_t tick_cnt;
  logic                    accept;
  logic                    tick;

  assign period_eff = (period < 16'd2) ? 16'd2 : period;
  assign accept     = load && !busy && load_steps != '0;
  assign tick       = busy && tick_cnt == 16'd1;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      step      <= 1'b0;
      dir       <= 1'b0;
      busy      <= 1'b0;
      remaining <= '0;
    end else if (accept) begin
      step      <= 1'b0;
      dir       <= load_dir;
      busy      <= 1'b1;
      remaining <= load_steps;
    end else if (tick) begin
      step      <= 1'b1;
      remaining <= remaining - 16'd1;
      if (remaining == 16'd1) busy <= 1'b0;  // Drops with the last pulse
    end else begin
      step <= 1'b0;
    end
  end

  // First pulse lands period cycles after the load
  always_ff @(posedge CLK) begin
    if (accept) begin
      period_q <= period_eff;
      tick_cnt <= period_eff - 16'd1;
    end else if (busy) begin
      tick_cnt <= tick ? period_q : tick_cnt - 16'd1;
    end
  end

endmodule

//--- stepper/hbridge_phase.sv
module hbridge_phase (
  input  logic                  CLK,
  input  logic                  resetn,
  input  logic                  step,
  input  logic                  dir,
  input  logic                  enable,
  input  motor_pkg::drive_cfg_t drive_cfg,
  output logic                  phase_a1,
  output logic                  phase_a2,
  output logic                  phase_b1,
  output logic                  phase_b2
);

  motor_pkg::phase_idx_t phase_idx;
  motor_pkg::phase_idx_t step_size;
  logic [7:0]            pwm_cnt;
  logic [1:0]            quadrant;
  logic [3:0]            offset;
  logic [7:0]            mag_lo;     // sin of the offset
  logic [7:0]            mag_hi;     // sin of 90 deg minus the offset
  logic [7:0]            cos_mag;
  logic [7:0]            sin_mag;
  logic [15:0]           cos_scaled;
  logic [15:0]           sin_scaled;
  logic                  a_on;
  logic                  b_on;
  logic                  a_pos;
  logic                  b_pos;

  function automatic logic [7:0] quarter_sine(input logic [4:0] i);
    case (i)
      5'd0:    return 8'd0;
      5'd1:    return 8'd25;
      5'd2:    return 8'd50;
      5'd3:    return 8'd74;
      5'd4:    return 8'd98;
      5'd5:    return 8'd120;
      5'd6:    return 8'd142;
      5'd7:    return 8'd162;
      5'd8:    return 8'd180;
      5'd9:    return 8'd197;
      5'd10:   return 8'd212;
      5'd11:   return 8'd225;
      5'd12:   return 8'd236;
      5'd13:   return 8'd244;
      5'd14:   return 8'd250;
      5'd15:   return 8'd254;
      default: return 8'd255;  // Peak
    endcase
  endfunction

  assign step_size = (drive_cfg.microsteps > 3'd4) ? 6'd1 : 6'd16 >> drive_cfg.microsteps;

  assign quadrant = phase_idx[5:4];
  assign offset   = phase_idx[3:0];
  assign mag_lo   = quarter_sine({1'b0, offset});
  assign mag_hi   = quarter_sine(5'd16 - {1'b0, offset});
  assign cos_mag  = quadrant[0] ? mag_lo : mag_hi;
  assign sin_mag  = quadrant[0] ? mag_hi : mag_lo;

  assign cos_scaled = cos_mag * drive_cfg.current;
  assign sin_scaled = sin_mag * drive_cfg.current;
  assign a_on       = pwm_cnt < cos_scaled[15:8];  // Zero duty never fires
  assign b_on       = pwm_cnt < sin_scaled[15:8];
  assign a_pos      = quadrant == 2'd0 || quadrant == 2'd3;
  assign b_pos      = !quadrant[1];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      phase_idx <= 6'd8;
      pwm_cnt   <= '0;
      phase_a1  <= 1'b0;
      phase_a2  <= 1'b0;
      phase_b1  <= 1'b0;
      phase_b2  <= 1'b0;
    end else begin
      pwm_cnt <= pwm_cnt + 8'd1;
      if (step) phase_idx <= dir ? phase_idx + step_size : phase_idx - step_size;
      phase_a1 <= enable && a_on && a_pos;
      phase_a2 <= enable && a_on && !a_pos;
      phase_b1 <= enable && b_on && b_pos;
      phase_b2 <= enable && b_on && !b_pos;
    end
  end

endmodule

//--- src/rapcore.sv
module rapcore #(
  parameter int motor_count = 2
) (
  input  logic                   CLK,
  input  logic                   resetn,
  input  logic                   sck,
  input  logic                   cs_n,
  input  logic                   copi,
  output logic                   cipo,
  input  logic                   enc_a,
  input  logic                   enc_b,
  output logic [motor_count-1:0] step_out,
  output logic [motor_count-1:0] dir_out,
  output logic [motor_count-1:0] move_done,
  output logic [motor_count-1:0] phase_a1,
  output logic [motor_count-1:0] phase_a2,
  output logic [motor_count-1:0] phase_b1,
  output logic [motor_count-1:0] phase_b2
);

  logic [3:0]                                  rst_cnt;
  logic                                        core_resetn;  // Stretched reset
  motor_pkg::wb_req_t                          wb_req;
  motor_pkg::wb_rsp_t                          wb_rsp;
  motor_pkg::enc_count_t                       enc_count;
  motor_pkg::drive_cfg_t                       drive_cfg;
  motor_pkg::step_period_t                     step_period;
  motor_pkg::step_count_t                      move_steps;
  motor_pkg::step_count_t [motor_count-1:0]    remaining;
  logic                                        move_dir;
  logic [motor_count-1:0]                      move_load;
  logic [motor_count-1:0]                      busy;
  logic [motor_count-1:0]                      enable;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      rst_cnt     <= '0;
      core_resetn <= 1'b0;
    end else if (rst_cnt == 4'hf) begin
      core_resetn <= 1'b1;
    end else begin
      rst_cnt <= rst_cnt + 4'd1;
    end
  end

  assign move_done = ~busy;

  spi_target spi (
    .CLK(CLK), .resetn(core_resetn),
    .sck(sck), .cs_n(cs_n), .copi(copi), .cipo(cipo),
    .wb_req(wb_req), .wb_rsp(wb_rsp)
  );

  motor_regs #(.motor_count(motor_count)) regs (
    .CLK(CLK), .resetn(core_resetn),
    .wb_req(wb_req), .wb_rsp(wb_rsp),
    .enc_count(enc_count), .busy(busy), .remaining(remaining),
    .enable(enable), .drive_cfg(drive_cfg), .step_period(step_period),
    .move_load(move_load), .move_dir(move_dir), .move_steps(move_steps)
  );

  quad_enc encoder0 (
    .CLK(CLK), .resetn(core_resetn), .a(enc_a), .b(enc_b), .count(enc_count)
  );

  for (genvar i = 0; i < motor_count; i++) begin : g_motor
    step_gen stepper (
      .CLK(CLK), .resetn(core_resetn),
      .load(move_load[i]), .load_dir(move_dir), .load_steps(move_steps),
      .period(step_period),
      .step(step_out[i]), .dir(dir_out[i]), .busy(busy[i]), .remaining(remaining[i])
    );

    hbridge_phase bridge (
      .CLK(CLK), .resetn(core_resetn),
      .step(step_out[i]), .dir(dir_out[i]), .enable(enable[i]), .drive_cfg(drive_cfg),
      .phase_a1(phase_a1[i]), .phase_a2(phase_a2[i]),
      .phase_b1(phase_b1[i]), .phase_b2(phase_b2[i])
    );
  end

endmodule

//--- dv/clk_gen.sv
module clk_gen #(
  parameter int half_period  = 10,
  parameter int reset_cycles = 4
) (
  output logic CLK,
  output logic resetn
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    CLK = 1'b0;
    forever #(half_period) CLK = ~CLK;
  end

  initial begin
    resetn = 1'b0;
    repeat (reset_cycles) @(posedge CLK);
    #2 resetn = 1'b1;  // Same offset as the other inputs
  end

endmodule

//--- dv/tb_rapcore.sv
module tb_rapcore;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int motors          = 2;
  localparam int frame_ns        = 420 * 20;  // SPI frame with CS lead and gap
  localparam int test_ns         = 40 * frame_ns + 8000 * 20;
  localparam int watchdog_ns     = test_ns + 20_000;
  localparam int move_plain      = 0;
  localparam int move_read_mid   = 1;
  localparam int move_write_busy = 2;

  logic              CLK;
  logic              resetn;
  logic              sck;
  logic              cs_n;
  logic              copi;
  logic              cipo;
  logic              enc_a;
  logic              enc_b;
  logic [motors-1:0] step_out;
  logic [motors-1:0] dir_out;
  logic [motors-1:0] move_done;
  logic [motors-1:0] phase_a1;
  logic [motors-1:0] phase_a2;
  logic [motors-1:0] phase_b1;
  logic [motors-1:0] phase_b2;
  logic [31:0]       rng;

  clk_gen clocks (.CLK(CLK), .resetn(resetn));

  rapcore #(.motor_count(motors)) dut (
    .CLK(CLK), .resetn(resetn), .sck(sck), .cs_n(cs_n), .copi(copi), .cipo(cipo),
    .enc_a(enc_a), .enc_b(enc_b), .step_out(step_out), .dir_out(dir_out),
    .move_done(move_done), .phase_a1(phase_a1), .phase_a2(phase_a2),
    .phase_b1(phase_b1), .phase_b2(phase_b2)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else
      abort_run($sformatf("MISMATCH at %0t: %s expected %h, actual %h",
                          $time, name, expected, actual));
  endtask

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic wait_clks(input int n);
    repeat (n) @(posedge CLK);
    #2;
  endtask

  task automatic sample_edge();
    @(posedge CLK);
    #1;
  endtask

  task automatic spi_frame(input logic wr, input motor_pkg::reg_addr_t adr,
                           input motor_pkg::reg_data_t wdat,
                           output motor_pkg::reg_data_t rdat);
    logic [39:0] frame;
    frame = {wr, adr, wdat};
    rdat  = '0;
    wait_clks(1);
    cs_n = 1'b0;
    for (int i = 39; i >= 0; i--) begin
      copi = frame[i];
      wait_clks(5);
      if (i < 32) rdat[i] = cipo;  // Just before the rising SCK
      sck = 1'b1;
      wait_clks(5);
      sck = 1'b0;
    end
    wait_clks(5);
    cs_n = 1'b1;
    copi = 1'b0;
    wait_clks(10);
  endtask

  task automatic spi_write(input motor_pkg::reg_addr_t adr, input motor_pkg::reg_data_t dat);
    motor_pkg::reg_data_t unused;
    spi_frame(1'b1, adr, dat, unused);
  endtask

  task automatic spi_read(input motor_pkg::reg_addr_t adr, output motor_pkg::reg_data_t dat);
    spi_frame(1'b0, adr, '0, dat);
  endtask

  task automatic read_expect(input motor_pkg::reg_addr_t adr,
                             input motor_pkg::reg_data_t expected, input string name);
    motor_pkg::reg_data_t rd;
    spi_read(adr, rd);
    check_value(name, expected, rd);
  endtask

  // Step timing, dir and move_done are checked cycle by cycle against the move
  task automatic check_move(input int m, input int steps, input int period,
                            input logic dir, input int mode);
    int                   t;
    int                   t_last;
    int                   pulses;
    int                   seen;
    int                   wait_n;
    logic                 exp_step;
    motor_pkg::reg_data_t rd;
    motor_pkg::reg_addr_t madr;
    madr   = motor_pkg::addr_move_base + motor_pkg::reg_addr_t'(m);
    t_last = steps * period - 1;
    pulses = 0;
    seen   = 0;
    spi_write(motor_pkg::addr_period, motor_pkg::reg_data_t'(period));
    fork
      begin
        spi_write(madr, {dir, 15'd0, 16'(steps)});
        if (mode == move_read_mid) begin
          while (pulses == 0) wait_clks(1);
          fork
            spi_read(madr, rd);
            begin
              wait_clks(80);  // Register is sampled right after the address byte
              seen = pulses;
            end
          join
          check_value($sformatf("move[%0d] remaining", m), 32'(steps - seen), rd);
        end else if (mode == move_write_busy) begin
          spi_write(madr, {~dir, 15'd0, 16'd5});  // Must be dropped
        end
      end
      begin
        wait_n = 0;
        while (move_done[m] !== 1'b0) begin
          sample_edge();
          wait_n++;
          assert (wait_n < 1000) else
            abort_run($sformatf("Move on motor %0d never started", m));
        end
        for (t = 0; t <= t_last + period + 20; t++) begin
          exp_step = t >= period - 1 && t <= t_last && (t - (period - 1)) % period == 0;
          check_value($sformatf("step_out[%0d]", m), 32'(exp_step), 32'(step_out[m]));
          check_value($sformatf("dir_out[%0d]", m), 32'(dir), 32'(dir_out[m]));
          check_value($sformatf("move_done[%0d]", m), 32'(t >= t_last), 32'(move_done[m]));
          if (step_out[m]) pulses++;
          sample_edge();
        end
        check_value($sformatf("pulse count[%0d]", m), 32'(steps), 32'(pulses));
      end
    join
  endtask

  task automatic check_coil(input string leg, input int m, input logic [5:0] idx,
                            input logic on, input logic pos, input int n1, input int n2);
    if (!on || pos) check_value($sformatf("%s2[%0d] high cycles", leg, m), 0, 32'(n2));
    if (!on || !pos) check_value($sformatf("%s1[%0d] high cycles", leg, m), 0, 32'(n1));
    if (on) begin
      assert ((pos ? n1 : n2) > 0) else
        abort_run($sformatf("%s%0d[%0d] never pulsed at phase index %0d",
                            leg, pos ? 1 : 2, m, idx));
    end
  endtask

  // One full PWM cycle
  task automatic check_legs(input int m, input logic [5:0] idx, input logic on);
    int n_a1;
    int n_a2;
    int n_b1;
    int n_b2;
    n_a1 = 0;
    n_a2 = 0;
    n_b1 = 0;
    n_b2 = 0;
    repeat (256) begin
      sample_edge();
      if (phase_a1[m]) n_a1++;
      if (phase_a2[m]) n_a2++;
      if (phase_b1[m]) n_b1++;
      if (phase_b2[m]) n_b2++;
    end
    check_coil("phase_a", m, idx, on, idx[5:4] == 2'd0 || idx[5:4] == 2'd3, n_a1, n_a2);
    check_coil("phase_b", m, idx, on, !idx[5], n_b1, n_b2);
  endtask

  task automatic check_registers();
    check_value("move_done", 32'((1 << motors) - 1), 32'(move_done));
    check_value("step_out", 0, 32'(step_out));
    check_value("phase legs", 0, 32'({phase_a1, phase_a2, phase_b1, phase_b2}));
    check_value("cipo", 0, 32'(cipo));
    read_expect(motor_pkg::addr_id, motor_pkg::id_value, "id register");
    read_expect(motor_pkg::addr_status, 32'((1 << motors) - 1), "status register");
    spi_write(motor_pkg::addr_config, 32'h00ab_0305);
    read_expect(motor_pkg::addr_config, 32'h00ab_0305, "config register");
    spi_write(motor_pkg::addr_period, 32'h0000_1234);
    read_expect(motor_pkg::addr_period, 32'h0000_1234, "period register");
    read_expect(7'h05, '0, "unmapped 0x05");
    read_expect(7'h12, '0, "unmapped 0x12");
    read_expect(7'h7f, '0, "unmapped 0x7f");
  endtask

  task automatic check_phase_drive();
    logic [5:0] idx0;
    int         k;
    idx0 = 6'd8;
    spi_write(motor_pkg::addr_config, 32'h00ff_0000);  // Enables off
    check_legs(0, idx0, 1'b0);
    check_legs(1, 6'd8, 1'b0);
    spi_write(motor_pkg::addr_config, 32'h00ff_0003);  // Full step, full current
    check_legs(0, idx0, 1'b1);
    check_legs(1, 6'd8, 1'b1);
    for (k = 0; k < 3; k++) begin
      check_move(0, 1, 2, 1'b1, move_plain);
      idx0 = idx0 + 6'd16;
      check_legs(0, idx0, 1'b1);
    end
    check_move(0, 2, 4, 1'b0, move_plain);
    idx0 = idx0 - 6'd32;
    check_legs(0, idx0, 1'b1);
    check_legs(1, 6'd8, 1'b1);
    spi_write(motor_pkg::addr_config, 32'h0000_0003);  // Zero current
    check_legs(0, idx0, 1'b0);
    check_legs(1, 6'd8, 1'b0);
  endtask

  task automatic check_encoder();
    int                   n_fwd;
    int                   n_rev;
    int                   pos;
    int                   k;
    motor_pkg::reg_data_t rd;
    rng   = next_random(rng);
    n_fwd = 1 + int'(rng % 32'd16);
    rng   = next_random(rng);
    n_rev = 1 + int'(rng % 32'd24);
    pos   = 0;
    wait_clks(1);
    for (k = 0; k < n_fwd + n_rev; k++) begin
      pos   = (k < n_fwd) ? (pos + 1) % 4 : (pos + 3) % 4;  // AB order 00 10 11 01
      enc_a = pos == 1 || pos == 2;
      enc_b = pos >= 2;
      wait_clks(5);
    end
    spi_read(motor_pkg::addr_encoder, rd);
    check_value("encoder count", 32'(n_fwd - n_rev), rd);
  endtask

  initial begin
    #(watchdog_ns);
    abort_run($sformatf("Watchdog expired after %0d ns, the run is hung", watchdog_ns));
  end

  initial begin
    int   m;
    int   k;
    int   steps;
    int   period;
    logic dir;
    sck   = 1'b0;
    cs_n  = 1'b1;
    copi  = 1'b0;
    enc_a = 1'b0;
    enc_b = 1'b0;
    rng   = 32'h7f86_17d6;
    @(posedge resetn);
    wait_clks(20);  // Past the reset stretch
    check_registers();
    check_phase_drive();
    for (m = 0; m < motors; m++) begin
      for (k = 0; k < 3; k++) begin
        rng    = next_random(rng);
        steps  = 1 + int'(rng % 32'd12);
        rng    = next_random(rng);
        period = 2 + int'(rng % 32'd19);
        rng    = next_random(rng);
        dir    = rng[0];
        check_move(m, steps, period, dir, move_plain);
      end
    end
    rng   = next_random(rng);
    steps = 3 + int'(rng % 32'd10);
    check_move(1, steps, 150, rng[4], move_read_mid);
    check_move(0, 8, 100, 1'b1, move_write_busy);
    check_encoder();
    $display("All tests passed");
    $finish;
  end

endmodule

//--- vlog.f
common/motor_pkg.sv
spi/spi_target.sv
src/motor_regs.sv
src/quad_enc.sv
stepper/step_gen.sv
stepper/hbridge_phase.sv
src/rapcore.sv
dv/clk_gen.sv
dv/tb_rapcore.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the rapcore testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_rapcore --Mdir obj_dir -f vlog.f; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_rapcore 2>&1)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "All tests passed"; then
  exit 0
fi

echo "Pass message not found"
exit 1
